//--- common/mem_dma_pkg.sv
// ##########################################################################
// Shared definitions for the DMA burst engine and its memory channel.
// Modules refer to these by scoped names; the top level takes its default
// word and address widths from here and passes them down as parameters.
// ##########################################################################

`default_nettype none

package mem_dma_pkg;

  // default sizes, 256 words of 32 bits
  parameter int DEFAULT_DATA_W = 32;
  parameter int DEFAULT_ADDR_W = 8;

  // burst length field, a burst carries 1 to 255 words
  parameter int LEN_W = 8;

  typedef logic [LEN_W-1:0] len_t;

  typedef enum logic {
    DMA_READ  = 1'b0,
    DMA_WRITE = 1'b1
  } dma_dir_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_READ  = 2'd1,   // one read issued per cycle
    ST_DRAIN = 2'd2,   // waiting for the last read word
    ST_WRITE = 2'd3
  } dma_state_e;

endpackage

`default_nettype wire

//--- common/mem_port_if.sv
// ##########################################################################
// Memory channel between the burst engine and the 1R1W memory.
// Control, write data and read data travel as separate strobed channels.
// The engine connects through modport ctrl, the memory through modport mem.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

interface mem_port_if #(
  parameter int ADDR_W = mem_dma_pkg::DEFAULT_ADDR_W,
  parameter int DATA_W = mem_dma_pkg::DEFAULT_DATA_W
);

  logic              read_v;
  logic [ADDR_W-1:0] read_addr;

  logic              write_v;     // write command, needs wdata_v to take effect
  logic [ADDR_W-1:0] write_addr;

  logic              wdata_v;
  logic [DATA_W-1:0] wdata;

  logic              rdata_v;     // one cycle after read_v
  logic [DATA_W-1:0] rdata;

  modport ctrl (
    output read_v, read_addr, write_v, write_addr, wdata_v, wdata,
    input  rdata_v, rdata
  );

  modport mem (
    input  read_v, read_addr, write_v, write_addr, wdata_v, wdata,
    output rdata_v, rdata
  );

endinterface

`default_nettype wire

//--- hdl/mem_1r1w_sync.sv
// ##########################################################################
// Synchronous memory with one read port and one write port.
// A read strobe returns the addressed word one clock later together with
// rdata_v. A write needs write_v and wdata_v in the same cycle. The array
// has no reset, so contents are unknown until written.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module mem_1r1w_sync #(
  parameter int ADDR_W = mem_dma_pkg::DEFAULT_ADDR_W,
  parameter int DATA_W = mem_dma_pkg::DEFAULT_DATA_W
) (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  mem_port_if.mem   port_i
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] mem_q [DEPTH];

  logic              write_en;
  logic [DATA_W-1:0] rdata_q;
  logic              rdata_v_q;

  // command and data must meet in the same cycle, and never during reset
  assign write_en = rst_n_i & port_i.write_v & port_i.wdata_v;

  always_ff @(posedge clk_i) begin
    if (write_en) begin
      mem_q[port_i.write_addr] <= port_i.wdata;
    end
  end

  // a same-cycle write to the read address is not yet visible here
  always_ff @(posedge clk_i) begin
    if (port_i.read_v) begin
      rdata_q <= mem_q[port_i.read_addr];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_v_q <= 1'b0;
    end else begin
      rdata_v_q <= port_i.read_v;
    end
  end

  assign port_i.rdata   = rdata_q;
  assign port_i.rdata_v = rdata_v_q;

endmodule

`default_nettype wire

//--- dma_engine/dma_burst_ctrl.sv
// ##########################################################################
// Burst engine in front of the memory channel. It takes one command at a
// time while idle: a direction, a base word address and a word count.
// Read bursts issue one read per cycle and stream the data out; write
// bursts store each strobed input word at the next address. Addresses wrap
// at the memory size and done_o pulses once the burst is complete.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module dma_burst_ctrl #(
  parameter int ADDR_W = mem_dma_pkg::DEFAULT_ADDR_W,
  parameter int DATA_W = mem_dma_pkg::DEFAULT_DATA_W
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,

  input  wire logic                  cmd_v_i,
  input  wire mem_dma_pkg::dma_dir_e cmd_dir_i,
  input  wire logic [ADDR_W-1:0]     cmd_addr_i,
  input  wire mem_dma_pkg::len_t     cmd_len_i,

  input  wire logic                  wr_data_v_i,
  input  wire logic [DATA_W-1:0]     wr_data_i,

  output logic                       rd_data_v_o,
  output logic [DATA_W-1:0]          rd_data_o,

  output logic                       busy_o,
  output logic                       done_o,

  mem_port_if.ctrl                   mem_o
);

  mem_dma_pkg::dma_state_e state_q;
  mem_dma_pkg::dma_state_e state_d;
  logic [ADDR_W-1:0]       addr_q;
  logic [ADDR_W-1:0]       addr_d;
  mem_dma_pkg::len_t       cnt_q;     // words still to issue or accept
  mem_dma_pkg::len_t       cnt_d;
  logic                    done_q;
  logic                    done_d;

  logic                    cmd_take;
  logic                    wr_fire;
  logic                    last_word;

  // zero-length commands are dropped here
  assign cmd_take  = (state_q == mem_dma_pkg::ST_IDLE) && cmd_v_i && (cmd_len_i != '0);
  assign wr_fire   = (state_q == mem_dma_pkg::ST_WRITE) && wr_data_v_i;
  assign last_word = (cnt_q == mem_dma_pkg::len_t'(1));

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    cnt_d   = cnt_q;
    done_d  = 1'b0;

    case (state_q)
      mem_dma_pkg::ST_IDLE: begin
        if (cmd_take) begin
          addr_d = cmd_addr_i;
          cnt_d  = cmd_len_i;
          if (cmd_dir_i == mem_dma_pkg::DMA_WRITE) begin
            state_d = mem_dma_pkg::ST_WRITE;
          end else begin
            state_d = mem_dma_pkg::ST_READ;
          end
        end
      end

      mem_dma_pkg::ST_READ: begin
        addr_d = addr_q + ADDR_W'(1);   // wraps at the memory size
        cnt_d  = cnt_q - mem_dma_pkg::len_t'(1);
        if (last_word) begin
          state_d = mem_dma_pkg::ST_DRAIN;
        end
      end

      mem_dma_pkg::ST_DRAIN: begin
        if (mem_o.rdata_v) begin      // last word is on the stream now
          state_d = mem_dma_pkg::ST_IDLE;
          done_d  = 1'b1;
        end
      end

      mem_dma_pkg::ST_WRITE: begin
        if (wr_fire) begin
          addr_d = addr_q + ADDR_W'(1);
          cnt_d  = cnt_q - mem_dma_pkg::len_t'(1);
          if (last_word) begin
            state_d = mem_dma_pkg::ST_IDLE;
            done_d  = 1'b1;
          end
        end
      end

      default: begin
        state_d = mem_dma_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= mem_dma_pkg::ST_IDLE;
      addr_q  <= '0;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      cnt_q   <= cnt_d;
      done_q  <= done_d;
    end
  end

  // write command stays up for the whole burst, the data strobe marks each word
  assign mem_o.read_v     = (state_q == mem_dma_pkg::ST_READ);
  assign mem_o.read_addr  = addr_q;
  assign mem_o.write_v    = (state_q == mem_dma_pkg::ST_WRITE);
  assign mem_o.write_addr = addr_q;
  assign mem_o.wdata_v    = wr_fire;
  assign mem_o.wdata      = wr_data_i;

  assign rd_data_v_o = mem_o.rdata_v;
  assign rd_data_o   = mem_o.rdata;

  assign busy_o = (state_q != mem_dma_pkg::ST_IDLE);
  assign done_o = done_q;

endmodule

`default_nettype wire

//--- hdl/mem_dma_top.sv
// ##########################################################################
// Top level of the memory channel with its DMA burst engine in front.
// All outside signals are plain ports; ADDR_W and DATA_W set here are
// passed down to the engine, the memory and the channel between them.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module mem_dma_top #(
  parameter int ADDR_W = mem_dma_pkg::DEFAULT_ADDR_W,
  parameter int DATA_W = mem_dma_pkg::DEFAULT_DATA_W
) (
  input  wire logic              clk_i,
  input  wire logic              rst_n_i,

  input  wire logic              cmd_v_i,
  input  wire logic              cmd_dir_i,   // 1 selects a write burst
  input  wire logic [ADDR_W-1:0] cmd_addr_i,
  input  wire mem_dma_pkg::len_t cmd_len_i,

  input  wire logic              wr_data_v_i,
  input  wire logic [DATA_W-1:0] wr_data_i,

  output logic                   rd_data_v_o,
  output logic [DATA_W-1:0]      rd_data_o,

  output logic                   busy_o,
  output logic                   done_o
);

  mem_port_if #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) mem_bus ();

  dma_burst_ctrl #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_dma (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_dir_i   (mem_dma_pkg::dma_dir_e'(cmd_dir_i)),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_len_i   (cmd_len_i),
    .wr_data_v_i (wr_data_v_i),
    .wr_data_i   (wr_data_i),
    .rd_data_v_o (rd_data_v_o),
    .rd_data_o   (rd_data_o),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .mem_o       (mem_bus.ctrl)
  );

  mem_1r1w_sync #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_mem (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .port_i  (mem_bus.mem)
  );

endmodule

`default_nettype wire

//--- dv/mem_dma_asserts.sv
// ##########################################################################
// Protocol checks on the DMA engine and its memory channel, bound into
// every mem_dma_top instance. Each failing property raises $error and
// bumps fail_count, which the testbench inspects at the end of the run.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module mem_dma_asserts (
  input wire logic                    clk_i,
  input wire logic                    rst_n_i,
  input wire logic                    busy_i,
  input wire logic                    done_i,
  input wire logic                    read_v_i,
  input wire logic                    rdata_v_i,
  input wire logic                    write_v_i,
  input wire logic                    wdata_v_i,
  input wire mem_dma_pkg::dma_state_e state_i
);

  int unsigned fail_count = 0;

  done_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |=> !done_i) else begin
    $error("done_o stayed high for more than one cycle");
    fail_count++;
  end

  done_not_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |-> !busy_i) else begin
    $error("busy_o high while done_o pulses");
    fail_count++;
  end

  // read data comes back exactly one clock after the read issue
  read_then_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    read_v_i |=> rdata_v_i) else begin
    $error("rdata_v missing one cycle after read_v");
    fail_count++;
  end

  valid_after_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rdata_v_i |-> $past(read_v_i)) else begin
    $error("rdata_v without a read issued the cycle before");
    fail_count++;
  end

  write_in_write_state: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (write_v_i && wdata_v_i) |-> (state_i == mem_dma_pkg::ST_WRITE)) else begin
    $error("memory write outside ST_WRITE");
    fail_count++;
  end

endmodule

bind mem_dma_top mem_dma_asserts u_asserts (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .busy_i    (busy_o),
  .done_i    (done_o),
  .read_v_i  (mem_bus.read_v),
  .rdata_v_i (mem_bus.rdata_v),
  .write_v_i (mem_bus.write_v),
  .wdata_v_i (mem_bus.wdata_v),
  .state_i   (u_dma.state_q)
);

`default_nettype wire

//--- dv/mem_dma_tb.sv
// ##########################################################################
// Testbench for the DMA burst engine and its memory. Runs write bursts,
// read-back, wraparound, ignored inputs and a random mix, keeping a shadow
// copy of the memory that a monitor uses to check every streamed word.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module mem_dma_tb;

  localparam int ADDR_W  = mem_dma_pkg::DEFAULT_ADDR_W;
  localparam int DATA_W  = mem_dma_pkg::DEFAULT_DATA_W;
  localparam int DEPTH   = 1 << ADDR_W;
  localparam int TIMEOUT = 100;   // cycles allowed for any single wait

  logic              clk_i;
  logic              rst_n_i;
  logic              cmd_v_i;
  logic              cmd_dir_i;
  logic [ADDR_W-1:0] cmd_addr_i;
  mem_dma_pkg::len_t cmd_len_i;
  logic              wr_data_v_i;
  logic [DATA_W-1:0] wr_data_i;
  logic              rd_data_v_o;
  logic [DATA_W-1:0] rd_data_o;
  logic              busy_o;
  logic              done_o;

  logic [DATA_W-1:0] shadow [DEPTH];
  bit                written [DEPTH];
  logic [ADDR_W-1:0] exp_addr_q [$];   // addresses of reads still to arrive

  mem_dma_top uut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_dir_i   (cmd_dir_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_len_i   (cmd_len_i),
    .wr_data_v_i (wr_data_v_i),
    .wr_data_i   (wr_data_i),
    .rd_data_v_o (rd_data_v_o),
    .rd_data_o   (rd_data_o),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [DATA_W-1:0] expected_word(logic [ADDR_W-1:0] addr);
    return shadow[addr];
  endfunction

  task automatic stop_on_failure();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic next_cycle(ref int cycles, input string what);
    if (cycles >= TIMEOUT) begin
      $display("timeout while waiting for %s", what);
      stop_on_failure();
    end
    @(negedge clk_i);
    cycles++;
  endtask

  // returns on the falling edge right after the command was taken
  task automatic send_cmd(mem_dma_pkg::dma_dir_e dir, logic [ADDR_W-1:0] addr,
                          mem_dma_pkg::len_t len);
    @(negedge clk_i);
    cmd_v_i    = 1'b1;
    cmd_dir_i  = dir;
    cmd_addr_i = addr;
    cmd_len_i  = len;
    @(negedge clk_i);
    cmd_v_i = 1'b0;
  endtask

  task automatic write_burst(logic [ADDR_W-1:0] base, mem_dma_pkg::len_t len);
    logic [ADDR_W-1:0] addr;
    int                gap;
    int                cycles;
    addr = base;
    send_cmd(mem_dma_pkg::DMA_WRITE, base, len);
    for (int i = 0; i < int'(len); i++) begin
      gap = $urandom_range(3, 0);
      wr_data_v_i = 1'b0;
      for (int g = 0; g < gap; g++) begin
        check_value("busy_o", busy_o, 1);
        @(negedge clk_i);
      end
      wr_data_v_i   = 1'b1;
      wr_data_i     = DATA_W'($urandom());
      shadow[addr]  = wr_data_i;
      written[addr] = 1'b1;
      addr++;
      check_value("busy_o", busy_o, 1);
      check_value("done_o", done_o, 0);
      @(negedge clk_i);
    end
    wr_data_v_i = 1'b0;
    cycles = 0;
    while (done_o !== 1'b1) begin
      next_cycle(cycles, "done_o after a write burst");
    end
    check_value("done_o delay after last word", cycles, 0);
    check_value("busy_o", busy_o, 0);
  endtask

  task automatic read_burst(logic [ADDR_W-1:0] base, mem_dma_pkg::len_t len);
    int k;
    for (int i = 0; i < int'(len); i++) begin
      exp_addr_q.push_back(base + ADDR_W'(i));
    end
    send_cmd(mem_dma_pkg::DMA_READ, base, len);
    k = 1;   // falling edges since the command was taken
    while (done_o !== 1'b1) begin
      check_value("rd_data_v_o", rd_data_v_o, (k >= 2) && (k <= int'(len) + 1));
      check_value("busy_o", busy_o, 1);
      next_cycle(k, "done_o after a read burst");
    end
    check_value("done_o cycle", k, int'(len) + 2);
    check_value("busy_o", busy_o, 0);
    check_value("rd_data_v_o", rd_data_v_o, 0);
    check_value("pending reads", exp_addr_q.size(), 0);
  endtask

  // reads from the first written address at or after start
  task automatic read_written_range(logic [ADDR_W-1:0] start, mem_dma_pkg::len_t max_len);
    mem_dma_pkg::len_t len;
    int                probe;
    probe = 0;
    while (!written[start] && probe < DEPTH) begin
      start++;
      probe++;
    end
    len = 1;
    while (len < max_len && written[ADDR_W'(start + len)]) begin
      len++;
    end
    read_burst(start, len);
  endtask

  always @(posedge clk_i) begin : read_monitor
    logic [ADDR_W-1:0] addr;
    if (rst_n_i && rd_data_v_o === 1'b1) begin
      if (exp_addr_q.size() == 0) begin
        $display("read data arrived with no read outstanding");
        stop_on_failure();
      end else begin
        addr = exp_addr_q.pop_front();
        check_value("rd_data_o", rd_data_o, expected_word(addr));
      end
    end
  end

  initial begin : stimulus
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] first_base;
    mem_dma_pkg::len_t len;
    mem_dma_pkg::len_t first_len;
    void'($urandom(32'h1b11_e497));
    rst_n_i     = 1'b0;
    cmd_v_i     = 1'b0;
    cmd_dir_i   = 1'b0;
    cmd_addr_i  = '0;
    cmd_len_i   = '0;
    wr_data_v_i = 1'b0;
    wr_data_i   = '0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;

    repeat (3) begin
      check_value("busy_o", busy_o, 0);
      check_value("done_o", done_o, 0);
      check_value("rd_data_v_o", rd_data_v_o, 0);
      @(negedge clk_i);
    end

    first_base = ADDR_W'($urandom());
    first_len  = mem_dma_pkg::len_t'($urandom_range(16, 1));
    write_burst(first_base, first_len);
    read_burst(first_base, first_len);

    // wraparound across the top of the memory
    write_burst(ADDR_W'(DEPTH - 3), 8);
    read_burst(ADDR_W'(DEPTH - 3), 8);

    send_cmd(mem_dma_pkg::DMA_WRITE, first_base, 0);
    repeat (3) begin
      check_value("busy_o", busy_o, 0);
      @(negedge clk_i);
    end
    repeat (4) begin
      wr_data_v_i = 1'b1;
      wr_data_i   = DATA_W'($urandom());
      check_value("busy_o", busy_o, 0);
      @(negedge clk_i);
    end
    wr_data_v_i = 1'b0;
    check_value("busy_o", busy_o, 0);
    read_burst(first_base, first_len);
    read_burst(ADDR_W'(DEPTH - 3), 8);

    repeat (40) begin
      base = ADDR_W'($urandom());
      len  = mem_dma_pkg::len_t'($urandom_range(16, 1));
      if ($urandom_range(1, 0) == 1) begin
        write_burst(base, len);
      end else begin
        read_written_range(base, len);
      end
    end

    if (uut.u_asserts.fail_count != 0) begin
      $display("protocol assertions failed %0d times", uut.u_asserts.fail_count);
      stop_on_failure();
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- build.f
common/mem_dma_pkg.sv
common/mem_port_if.sv
hdl/mem_1r1w_sync.sv
dma_engine/dma_burst_ctrl.sv
hdl/mem_dma_top.sv
dv/mem_dma_asserts.sv
dv/mem_dma_tb.sv
